/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import singleCpuPkg::*; (
    input  wire logic [xlen-1:0] a,
    input  wire logic [xlen-1:0] b,
    input  wire aluOpT           op,
    output logic [xlen-1:0]      result,
    output logic                 zero
);

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluSlt:  result = {{(xlen-1){1'b0}}, lessThan};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);  // beq condition

endmodule

`default_nettype wire

/* dataMem.sv */
`timescale 1ns/1ps
`default_nettype none

module dataMem import singleCpuPkg::*; (
    input  wire logic            CLK,
    input  wire logic            reset,
    input  wire logic [xlen-1:0] addr,
    input  wire logic [xlen-1:0] writeData,
    input  wire logic            writeEnable,
    input  wire logic            readEnable,
    output logic [xlen-1:0]      readData
);

    localparam int indexBits = $clog2(dataMemWords);

    logic [xlen-1:0]      mem [dataMemWords];
    logic [indexBits-1:0] index;

    assign index = addr[indexBits+1:2];  // Word index from byte address

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < dataMemWords; i++) begin
                mem[i] <= '0;
            end
        end else if (writeEnable) begin
            mem[index] <= writeData;
        end
    end

    assign readData = readEnable ? mem[index] : '0;

    // Decoder raises at most one of these per instruction
    oneAccess: assert property (@(posedge CLK) disable iff (reset)
        !(readEnable && writeEnable))
        else $error("load and store in the same cycle");

endmodule

`default_nettype wire

/* instDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instDecoder import singleCpuPkg::*; (
    input  wire logic [xlen-1:0]    inst,
    output logic [regAddrBits-1:0]  rs1,
    output logic [regAddrBits-1:0]  rs2,
    output logic [regAddrBits-1:0]  rd,
    output logic [xlen-1:0]         imm,
    output aluOpT                   aluOp,
    output logic                    aluSrc,
    output logic                    regWrite,
    output logic                    memRead,
    output logic                    memWrite,
    output logic                    memToReg,
    output logic                    branch
);

    opcodeT     opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;

    assign opcode   = opcodeT'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign funct7b5 = inst[30];  // Separates sub from add

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        aluOp    = aluAdd;
        aluSrc   = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        branch   = 1'b0;
        imm      = immI;
        case (opcode)
            opR: begin
                regWrite = 1'b1;
                case (funct3)
                    3'b000:  aluOp = funct7b5 ? aluSub : aluAdd;
                    3'b111:  aluOp = aluAnd;
                    3'b110:  aluOp = aluOr;
                    3'b010:  aluOp = aluSlt;
                    default: aluOp = aluAdd;
                endcase
            end
            opImm: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            opLoad: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
            end
            opStore: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                imm      = immS;
            end
            opBranch: begin
                aluOp  = aluSub;  // Equal operands give zero
                branch = 1'b1;
                imm    = immB;
            end
            default: ;  // Unknown opcode behaves as a no-op
        endcase
    end

    // The ROM holds only opcodes this core decodes
    always_comb begin
        if (!$isunknown(inst)) begin
            knownOpcode: assert (opcode inside {opR, opImm, opLoad, opStore, opBranch})
                else $error("unknown opcode %b", inst[6:0]);
        end
    end

endmodule

`default_nettype wire

/* instMem.sv */
`timescale 1ns/1ps
`default_nettype none

module instMem import singleCpuPkg::*; (
    input  wire logic [xlen-1:0] addr,
    output logic [xlen-1:0]      inst
);

    localparam int indexBits = $clog2(instMemWords);

    logic [xlen-1:0]      rom [instMemWords];
    logic [indexBits-1:0] index;

    initial begin
        $readmemh("program.hex", rom);
    end

    assign index = addr[indexBits+1:2];  // Drop byte offset
    assign inst  = rom[index];

    // Upper address bits would otherwise alias into the ROM
    always_comb begin
        if (!$isunknown(addr)) begin
            fetchInRange: assert (addr[xlen-1:2] < instMemWords)
                else $error("fetch outside ROM at %h", addr);
        end
    end

endmodule

`default_nettype wire

/* program.hex */
// One 32-bit instruction word per line
// Byte address and assembly follow each word
00500093  // 00 addi x1,x0,5
ffd00113  // 04 addi x2,x0,-3
002081b3  // 08 add  x3,x1,x2
40208233  // 0c sub  x4,x1,x2
0020f2b3  // 10 and  x5,x1,x2
0020e333  // 14 or   x6,x1,x2
001123b3  // 18 slt  x7,x2,x1
00402423  // 1c sw   x4,8(x0)
00802403  // 20 lw   x8,8(x0)
00440463  // 24 beq  x8,x4,+8
06300493  // 28 addi x9,x0,99
00208463  // 2c beq  x1,x2,+8
00700013  // 30 addi x0,x0,7
00000533  // 34 add  x10,x0,x0
00000063  // 38 beq  x0,x0,0

/* programCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module programCounter import singleCpuPkg::*; (
    input  wire logic            CLK,
    input  wire logic            reset,
    input  wire logic            branch,
    input  wire logic            zero,
    input  wire logic [xlen-1:0] imm,
    output logic [xlen-1:0]      pc
);

    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] branchTarget;
    logic [xlen-1:0] nextPc;
    logic            takeBranch;

    assign pcPlus4      = pc + xlen'(4);
    assign branchTarget = pc + imm;  // B immediate already has bit 0 clear
    assign takeBranch   = branch & zero;
    assign nextPc       = takeBranch ? branchTarget : pcPlus4;

    always_ff @(posedge CLK) begin
        if (reset) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

    // A misaligned target would come from a bad immediate
    pcAligned: assert property (@(posedge CLK) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

/* registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile import singleCpuPkg::*; (
    input  wire logic                   CLK,
    input  wire logic                   reset,
    input  wire logic [regAddrBits-1:0] readAddr1,
    input  wire logic [regAddrBits-1:0] readAddr2,
    input  wire logic [regAddrBits-1:0] writeAddr,
    input  wire logic [xlen-1:0]        writeData,
    input  wire logic                   writeEnable,
    output logic [xlen-1:0]             readData1,
    output logic [xlen-1:0]             readData2
);

    localparam int numRegs = 2 ** regAddrBits;

    logic [xlen-1:0] regs [numRegs];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin  // x0 never written
            regs[writeAddr] <= writeData;
        end
    end

    // Asynchronous reads
    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

    // x0 cleared by reset and kept by the write guard
    x0ReadsZero: assert property (@(posedge CLK) disable iff (reset)
        ((readAddr1 == '0) |-> (readData1 == '0)) and
        ((readAddr2 == '0) |-> (readData2 == '0)))
        else $error("x0 read back nonzero");

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the singleCpu testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module singleCpuTb -f singleCpu.f -o singleCpuSim

output=$(./obj_dir/singleCpuSim)
echo "$output"

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi

/* singleCpu.f */
singleCpuPkg.sv
programCounter.sv
instMem.sv
instDecoder.sv
registerFile.sv
alu.sv
dataMem.sv
singleCpu.sv
singleCpuTb.sv

/* singleCpu.sv */
`timescale 1ns/1ps
`default_nettype none

module singleCpu import singleCpuPkg::*; (
    input  wire logic                   CLK,
    input  wire logic                   reset,
    output logic [xlen-1:0]             pc,
    output logic                        regWriteEnable,
    output logic [regAddrBits-1:0]      regWriteAddr,
    output logic [xlen-1:0]             regWriteData,
    output logic                        memWriteEnable,
    output logic [xlen-1:0]             memAddr,
    output logic [xlen-1:0]             memWriteData
);

    logic [xlen-1:0]        inst;
    logic [regAddrBits-1:0] rs1;
    logic [regAddrBits-1:0] rs2;
    logic [regAddrBits-1:0] rd;
    logic [xlen-1:0]        imm;
    aluOpT                  aluOp;
    logic                   aluSrc;
    logic                   regWrite;
    logic                   memRead;
    logic                   memWrite;
    logic                   memToReg;
    logic                   branch;
    logic [xlen-1:0]        readData1;
    logic [xlen-1:0]        readData2;
    logic [xlen-1:0]        aluB;
    logic [xlen-1:0]        result;
    logic                   zero;
    logic [xlen-1:0]        memReadData;
    logic [xlen-1:0]        writeBackData;

    programCounter programCounter_inst (
        .CLK(CLK), .reset(reset), .branch(branch), .zero(zero), .imm(imm), .pc(pc)
    );

    instMem instMem_inst (.addr(pc), .inst(inst));

    instDecoder instDecoder_inst (
        .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .aluOp(aluOp),
        .aluSrc(aluSrc), .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
        .memToReg(memToReg), .branch(branch)
    );

    registerFile registerFile_inst (
        .CLK(CLK), .reset(reset), .readAddr1(rs1), .readAddr2(rs2), .writeAddr(rd),
        .writeData(writeBackData), .writeEnable(regWriteEnable),
        .readData1(readData1), .readData2(readData2)
    );

    assign aluB = aluSrc ? imm : readData2;  // Immediate or rs2

    alu alu_inst (.a(readData1), .b(aluB), .op(aluOp), .result(result), .zero(zero));

    dataMem dataMem_inst (
        .CLK(CLK), .reset(reset), .addr(result), .writeData(readData2),
        .writeEnable(memWriteEnable), .readEnable(memRead), .readData(memReadData)
    );

    assign writeBackData = memToReg ? memReadData : result;

    // Commit strobes held low while in reset
    assign regWriteEnable = regWrite & ~reset;
    assign memWriteEnable = memWrite & ~reset;
    assign regWriteAddr   = rd;
    assign regWriteData   = writeBackData;
    assign memAddr        = result;
    assign memWriteData   = readData2;

endmodule

`default_nettype wire

/* singleCpuPkg.sv */
`default_nettype none

package singleCpuPkg;

    // Datapath and register file widths
    localparam int xlen        = 32;
    localparam int regAddrBits = 5;

    // Memory depths in 32-bit words
    localparam int instMemWords = 64;
    localparam int dataMemWords = 64;

    localparam logic [xlen-1:0] resetPc = '0;  // First fetch address

    // RV32I major opcodes handled by this core
    typedef enum logic [6:0] {
        opR      = 7'b0110011,  // add sub and or slt
        opImm    = 7'b0010011,  // addi
        opLoad   = 7'b0000011,  // lw
        opStore  = 7'b0100011,  // sw
        opBranch = 7'b1100011   // beq
    } opcodeT;

    // ALU operations
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4   // Signed compare
    } aluOpT;

endpackage

`default_nettype wire

/* singleCpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module singleCpuTb import singleCpuPkg::*; ();

    localparam int resetCycles   = 5;
    localparam int programLength = 15;
    localparam int cycleLimit    = 6 * programLength + 10;  // Halt loop runs until here
    localparam int numTests      = 6;
    localparam int numWrites     = 10;
    localparam logic [xlen-1:0] haltPc = 32'd56;

    // Test indices
    localparam int testReset     = 0;
    localparam int testWriteBack = 1;
    localparam int testStoreLoad = 2;
    localparam int testBranch    = 3;
    localparam int testZeroReg   = 4;
    localparam int testHalt      = 5;

    logic CLK   = 1'b0;
    logic reset = 1'b1;

    logic [xlen-1:0]        pc;
    logic                   regWriteEnable;
    logic [regAddrBits-1:0] regWriteAddr;
    logic [xlen-1:0]        regWriteData;
    logic                   memWriteEnable;
    logic [xlen-1:0]        memAddr;
    logic [xlen-1:0]        memWriteData;

    // Register writes in program order with no x9 since its addi is skipped
    logic [regAddrBits-1:0] expWriteAddr [numWrites] =
        '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd0, 5'd10};
    logic [xlen-1:0] expWriteData [numWrites] =
        '{32'd5, 32'hffff_fffd, 32'd2, 32'd8, 32'd5, 32'hffff_fffd, 32'd1, 32'd8, 32'd7, 32'd0};

    string testName [numTests] =
        '{"resetState", "writeBack", "storeLoad", "branches", "zeroReg", "haltLoop"};
    int    testErrors [numTests] = '{default: 0};
    bit    testDone [numTests]   = '{default: 1'b0};

    int              cycle = 0;
    int              writeIdx = 0;
    int              storeCount = 0;
    int              haltCycles = 0;
    logic [xlen-1:0] prevPc;

    singleCpu singleCpu_inst (
        .CLK(CLK), .reset(reset), .pc(pc),
        .regWriteEnable(regWriteEnable), .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData), .memWriteEnable(memWriteEnable),
        .memAddr(memAddr), .memWriteData(memWriteData)
    );

    always #5 CLK = ~CLK;

    task automatic checkValue(input int test, input string what,
                              input logic [xlen-1:0] expected, input logic [xlen-1:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s %s expected %h actual %h", testName[test], what, expected, actual);
            testErrors[test]++;
        end
    endtask

    task automatic reportFault(input int test, input string msg);
        $display("%s went wrong: %s", testName[test], msg);
        testErrors[test]++;
    endtask

    task automatic finishTest(input int test);
        if (!testDone[test]) begin
            testDone[test] = 1'b1;
            if (testErrors[test] == 0) begin
                $display("test %s passed", testName[test]);
            end else begin
                $display("test %s failed with %0d errors", testName[test], testErrors[test]);
            end
        end
    endtask

    // Branch layout of the program
    function automatic logic [xlen-1:0] nextPcAfter(input logic [xlen-1:0] current);
        case (current)
            32'd36:  return 32'd44;  // beq x8,x4 taken
            haltPc:  return haltPc;
            default: return current + 32'd4;
        endcase
    endfunction

    function automatic int writeOwner(input int idx);
        if (idx == 7) return testStoreLoad;  // lw result
        if (idx >= 8) return testZeroReg;
        return testWriteBack;
    endfunction

    task automatic checkWrite();
        int owner;
        if (regWriteAddr == 5'd9) reportFault(testBranch, "skipped addi wrote x9");
        if (writeIdx < numWrites) begin
            owner = writeOwner(writeIdx);
            checkValue(owner, "write addr", xlen'(expWriteAddr[writeIdx]), xlen'(regWriteAddr));
            checkValue(owner, "write data", expWriteData[writeIdx], regWriteData);
            writeIdx++;
            if (writeIdx == 8) begin
                if (storeCount != 1) reportFault(testStoreLoad, "no single store before the load");
                finishTest(testStoreLoad);
            end
            if (writeIdx == numWrites) begin
                finishTest(testWriteBack);
                finishTest(testZeroReg);
            end
        end else begin
            reportFault(testWriteBack, "more register writes than the program makes");
        end
    endtask

    task automatic checkStore();
        storeCount++;
        if (storeCount == 1) begin
            checkValue(testStoreLoad, "store addr", 32'd8, memAddr);
            checkValue(testStoreLoad, "store data", 32'd8, memWriteData);
        end else begin
            reportFault(testHalt, "store strobe after the single sw");
        end
    endtask

    // Outputs sampled before the edge commits them
    always @(posedge CLK) begin
        if (!reset) begin
            if (cycle == 0) begin
                checkValue(testReset, "first pc", resetPc, pc);
                finishTest(testReset);
            end else begin
                checkValue(prevPc == haltPc ? testHalt : testBranch, "pc",
                           nextPcAfter(prevPc), pc);
                if (prevPc == 32'd44) finishTest(testBranch);  // Untaken beq just checked
            end
            if (regWriteEnable) checkWrite();
            if (memWriteEnable) checkStore();
            if (pc == haltPc) begin
                haltCycles++;
                assert (!regWriteEnable && !memWriteEnable)
                    else reportFault(testHalt, "write strobe inside the halt loop");
            end
            prevPc = pc;
            cycle <= cycle + 1;
        end
    end

    noCommitInReset: assert property (@(posedge CLK) reset |-> !regWriteEnable && !memWriteEnable)
        else reportFault(testReset, "write strobe raised during reset");

    haltHolds: assert property (@(posedge CLK) disable iff (reset)
        (pc == haltPc) |=> (pc == haltPc))
        else reportFault(testHalt, "pc left the halt loop");

    initial begin
        int totalErrors;
        int failed;
        totalErrors = 0;
        failed = 0;
        repeat (resetCycles) @(posedge CLK);
        reset <= 1'b0;
        while (cycle < cycleLimit) @(posedge CLK);
        @(negedge CLK);
        if (haltCycles == 0) reportFault(testHalt, "halt loop not reached before the cycle limit");
        for (int i = 0; i < numTests; i++) begin
            if (!testDone[i] && i != testHalt) begin
                reportFault(i, "did not complete before the cycle limit");
            end
            finishTest(i);
            totalErrors += testErrors[i];
            if (testErrors[i] != 0) failed++;
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 numTests, numTests - failed, failed, totalErrors);
        if (totalErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
